//--- hw/gng_main_pkg.sv
`default_nettype none

package gng_main_pkg;

    // Bus widths
    parameter int addr_w     = 16;                 // 6809 address bus
    parameter int data_w     = 8;                  // 6809 data bus
    parameter int rom_addr_w = 17;                 // 128 kB of program ROM
    parameter int bank_w     = 3;                  // Bank register width

    // One bit per decoded region, at most one set
    typedef struct packed {
        logic snd;                                 // Sound latch 3A00
        logic okout;                               // Object copy start 3C00
        logic scrpos;                              // Scroll position 3B00
        logic scr;                                 // Scroll RAM 2800-2FFF
        logic cab;                                 // Cabinet inputs 3000-37FF
        logic blue;                                // Blue palette 3900
        logic redgreen;                            // Red/green palette 3800
        logic ctrl;                                // Flip, sound reset, coins 3D00
        logic ram;                                 // Work RAM 0000-1FFF
        logic chr;                                 // Character RAM 2000-27FF
        logic bank;                                // Bank register 3E00
        logic rom;                                 // Program ROM 4000-FFFF
    } sel_t;

    // ROM pages for the 4000-7FFF windows
    parameter logic [3:0] rom_page_fixed     = 4'd5;   // 6000-7FFF
    parameter logic [3:0] rom_page_bank4     = 4'd4;   // 4000-5FFF when bank is 4
    parameter logic [3:0] rom_page_bank_base = 4'd6;   // First switchable page

    // DIP defaults
    parameter logic [4:0] dipsw_a_coin   = 5'h1f;      // 1 coin, 1 credit
    parameter logic [7:0] dipsw_b_fixed  = 8'b011_11_0_11; // Normal, default bonus, 3 lives

endpackage

`default_nettype wire

//--- hw/gng_cpu_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface gng_cpu_bus_if;

    logic                              cen;    // 6 MHz clock enable, one bus cycle
    logic [gng_main_pkg::addr_w-1:0]   addr;   // CPU address
    logic [gng_main_pkg::data_w-1:0]   wdata;  // CPU write data
    logic                              rnw;    // High for read
    gng_main_pkg::sel_t                sel;    // Decoded region selects

    // Address decoder side
    modport dec (
        input  addr,
        output sel
    );

    // Register, RAM and input blocks
    modport slave (
        input  cen,
        input  addr,
        input  wdata,
        input  rnw,
        input  sel
    );

endinterface

`default_nettype wire

//--- hw/gng_bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

module gng_bus_decode (
    gng_cpu_bus_if.dec                           bus,
    input  wire [gng_main_pkg::bank_w-1:0]       bank,       // From bank register
    input  wire [gng_main_pkg::data_w-1:0]       ram_q,      // Registered RAM read
    input  wire [gng_main_pkg::data_w-1:0]       char_dout,
    input  wire [gng_main_pkg::data_w-1:0]       scr_dout,
    input  wire [gng_main_pkg::data_w-1:0]       rom_dout,
    input  wire [gng_main_pkg::data_w-1:0]       cab_dout,
    output logic [gng_main_pkg::rom_addr_w-1:0]  rom_addr,
    output logic [gng_main_pkg::data_w-1:0]      cpu_din
);

    gng_main_pkg::sel_t sel;                     // Local copy, also steers read data
    logic [3:0]         page;                    // ROM page above the 8 kB offset

    // Memory map on the high address byte
    always_comb begin
        sel = '0;
        casez (bus.addr[15:8])
            8'b000?_????: sel.ram      = 1'b1;   // 0000-1FFF
            8'b0010_0???: sel.chr      = 1'b1;   // 2000-27FF
            8'b0010_1???: sel.scr      = 1'b1;   // 2800-2FFF
            8'b0011_0???: sel.cab      = 1'b1;   // 3000-37FF
            8'b0011_1000: sel.redgreen = 1'b1;   // 3800
            8'b0011_1001: sel.blue     = 1'b1;   // 3900
            8'b0011_1010: sel.snd      = 1'b1;   // 3A00
            8'b0011_1011: sel.scrpos   = 1'b1;   // 3B00
            8'b0011_1100: sel.okout    = 1'b1;   // 3C00
            8'b0011_1101: sel.ctrl     = 1'b1;   // 3D00
            8'b0011_1110: sel.bank     = 1'b1;   // 3E00
            8'b01??_????: sel.rom      = 1'b1;   // 4000-7FFF
            8'b1???_????: sel.rom      = 1'b1;   // 8000-FFFF
            default:      sel          = '0;     // 3F00 and gaps
        endcase
    end

    assign bus.sel = sel;

    // Banked ROM page
    always_comb begin
        casez (bus.addr[15:13])
            3'b1??:  page = {2'b00, bus.addr[14:13]};       // Fixed 32 kB
            3'b011:  page = gng_main_pkg::rom_page_fixed;   // Fixed 8 kB
            3'b010: begin                                   // Switchable window
                if (bank == 3'd4)
                    page = gng_main_pkg::rom_page_bank4;
                else
                    page = gng_main_pkg::rom_page_bank_base + {2'b00, bank[1:0]};
            end
            default: page = 4'd0;                           // No ROM below 4000
        endcase
    end

    assign rom_addr = {page, bus.addr[12:0]};

    // Read data back to the CPU
    always_comb begin
        case ({sel.ram, sel.chr, sel.scr, sel.rom, sel.cab})
            5'b10000: cpu_din = ram_q;
            5'b01000: cpu_din = char_dout;
            5'b00100: cpu_din = scr_dout;
            5'b00010: cpu_din = rom_dout;
            5'b00001: cpu_din = cab_dout;
            default:  cpu_din = rom_dout;   // Unmapped reads float to ROM
        endcase
    end

endmodule

`default_nettype wire

//--- hw/gng_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module gng_ctrl_regs #(
    parameter int coin_w = 4
) (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                soft_rst,   // Held CPU reset request
    input  wire                                lvbl,       // Low during vertical blank
    input  wire                                irq_ack,    // Interrupt acknowledge
    gng_cpu_bus_if.slave                       bus,
    output logic [gng_main_pkg::bank_w-1:0]    bank,
    output logic                               flip,
    output logic                               sres_n,     // Sound CPU reset, low active
    output logic                               cpu_rst,
    output logic                               irq_n,
    output logic [gng_main_pkg::data_w-1:0]    snd_latch,
    output logic [coin_w-1:0]                  coin_cnt1,
    output logic [coin_w-1:0]                  coin_cnt2
);

    logic wr;            // Write strobe for this bus cycle
    logic lvbl_q;        // Last lvbl sample
    logic lvbl_qq;       // Sample before that
    logic [coin_w-1:0] coin_inc;

    assign wr       = bus.cen & ~bus.rnw;
    assign coin_inc = {{(coin_w-1){1'b0}}, bus.wdata[0]};   // Counter pulse from bit 0

    // Write-only registers
    always_ff @(posedge clk) begin
        if (rst) begin
            bank      <= '0;
            flip      <= 1'b0;
            sres_n    <= 1'b1;
            snd_latch <= '0;
            coin_cnt1 <= '0;
            coin_cnt2 <= '0;
        end else if (wr) begin
            if (bus.sel.bank)
                bank <= bus.wdata[gng_main_pkg::bank_w-1:0];
            if (bus.sel.snd)
                snd_latch <= bus.wdata;
            if (bus.sel.ctrl) begin
                case (bus.addr[2:0])
                    3'd0:    flip      <= bus.wdata[0];
                    3'd1:    sres_n    <= bus.wdata[0];
                    3'd2:    coin_cnt1 <= coin_cnt1 + coin_inc;
                    3'd3:    coin_cnt2 <= coin_cnt2 + coin_inc;
                    default: ;   // 3D04-3D07 unused
                endcase
            end
        end
    end

    // CPU reset held until a bus cycle with soft reset released
    always_ff @(posedge clk) begin
        if (rst)
            cpu_rst <= 1'b1;
        else if (bus.cen)
            cpu_rst <= soft_rst;
    end

    // VBlank falling edge sets the IRQ, ack clears it
    always_ff @(posedge clk) begin
        if (rst) begin
            lvbl_q  <= 1'b0;     // No edge seen straight out of reset
            lvbl_qq <= 1'b0;
            irq_n   <= 1'b1;
        end else if (bus.cen) begin
            lvbl_q  <= lvbl;
            lvbl_qq <= lvbl_q;
            if (irq_ack)
                irq_n <= 1'b1;                   // Ack wins over a new edge
            else if (lvbl_qq && !lvbl_q)
                irq_n <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hw/gng_cabinet_in.sv
`timescale 1ns/1ps
`default_nettype none

module gng_cabinet_in (
    gng_cpu_bus_if.slave                      bus,
    input  wire [7:0]                         joystick1,     // Bit 7 coin, 6 start, 5-0 stick
    input  wire [7:0]                         joystick2,
    input  wire                               dip_flip,
    input  wire                               dip_game_mode,
    input  wire                               dip_attract_snd,
    input  wire                               dip_upright,
    output logic [gng_main_pkg::data_w-1:0]   cab_dout
);

    logic [7:0] dipsw_a;
    logic [7:0] dipsw_b;

    assign dipsw_a = {dip_flip, dip_game_mode, dip_attract_snd, gng_main_pkg::dipsw_a_coin};
    assign dipsw_b = gng_main_pkg::dipsw_b_fixed | {5'b0, dip_upright, 2'b0};   // Upright at bit 2

    // Port selected by the low address nibble
    always_comb begin
        case (bus.addr[3:0])
            4'd0:    cab_dout = {joystick2[7], joystick1[7], 4'hf,    // Coins, filler
                                 joystick2[6], joystick1[6]};          // Start buttons
            4'd1:    cab_dout = {2'b11, joystick1[5:0]};
            4'd2:    cab_dout = {2'b11, joystick2[5:0]};
            4'd3:    cab_dout = dipsw_a;
            4'd4:    cab_dout = dipsw_b;
            default: cab_dout = 8'hff;           // Open bus reads high
        endcase
    end

endmodule

`default_nettype wire

//--- hw/gng_work_ram.sv
`timescale 1ns/1ps
`default_nettype none

module gng_work_ram #(
    parameter int ram_aw = 13
) (
    input  wire                                clk,
    gng_cpu_bus_if.slave                       bus,
    input  wire                                blcnten,    // Object engine owns the RAM
    input  wire  [8:0]                         obj_addr,   // Object table offset
    output logic [gng_main_pkg::data_w-1:0]    ram_q
);

    logic [gng_main_pkg::data_w-1:0] mem [2**ram_aw];
    logic [ram_aw-1:0]               addr;
    logic                            we;

    // Object engine reads the top page, CPU is locked out
    always_comb begin
        if (blcnten) begin
            addr = {{(ram_aw-9){1'b1}}, obj_addr};
            we   = 1'b0;
        end else begin
            addr = bus.addr[ram_aw-1:0];
            we   = bus.sel.ram & ~bus.rnw;
        end
    end

    // Single port, read before write
    always_ff @(posedge clk) begin
        if (bus.cen) begin
            if (we)
                mem[addr] <= bus.wdata;
            ram_q <= mem[addr];
        end
    end

endmodule

`default_nettype wire

//--- hw/gng_main_bus.sv
`timescale 1ns/1ps
`default_nettype none

module gng_main_bus #(
    parameter int ram_aw = 13,
    parameter int coin_w = 4
) (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  soft_rst,
    input  wire                                  cen6,        // 6 MHz bus cycle
    // CPU bus
    input  wire [gng_main_pkg::addr_w-1:0]       cpu_addr,
    input  wire [gng_main_pkg::data_w-1:0]       cpu_dout,    // CPU write data
    input  wire                                  cpu_rnw,
    output wire [gng_main_pkg::data_w-1:0]       cpu_din,
    input  wire                                  irq_ack,
    input  wire                                  lvbl,
    output wire                                  irq_n,
    output wire                                  cpu_rst,
    // Video and ROM
    input  wire [gng_main_pkg::data_w-1:0]       char_dout,
    input  wire [gng_main_pkg::data_w-1:0]       scr_dout,
    input  wire [gng_main_pkg::data_w-1:0]       rom_dout,
    output wire [gng_main_pkg::rom_addr_w-1:0]   rom_addr,
    // Object engine RAM access
    input  wire                                  blcnten,
    input  wire [8:0]                            obj_addr,
    output wire [gng_main_pkg::data_w-1:0]       ram_dout,
    // Chip selects
    output wire                                  char_cs,
    output wire                                  scr_cs,
    output wire                                  scrpos_cs,
    output wire                                  blue_cs,
    output wire                                  redgreen_cs,
    output wire                                  okout,
    output wire                                  main_cs,
    // Control registers
    output wire                                  flip,
    output wire                                  sres_n,
    output wire [gng_main_pkg::data_w-1:0]       snd_latch,
    output wire [coin_w-1:0]                     coin_cnt1,
    output wire [coin_w-1:0]                     coin_cnt2,
    // Cabinet
    input  wire [7:0]                            joystick1,
    input  wire [7:0]                            joystick2,
    input  wire                                  dip_flip,
    input  wire                                  dip_game_mode,
    input  wire                                  dip_attract_snd,
    input  wire                                  dip_upright
);

    gng_cpu_bus_if bus ();

    wire [gng_main_pkg::bank_w-1:0] bank;
    wire [gng_main_pkg::data_w-1:0] cab_dout;

    assign bus.cen   = cen6;
    assign bus.addr  = cpu_addr;
    assign bus.wdata = cpu_dout;
    assign bus.rnw   = cpu_rnw;

    // Selects leaving the board
    assign char_cs     = bus.sel.chr;
    assign scr_cs      = bus.sel.scr;
    assign scrpos_cs   = bus.sel.scrpos;
    assign blue_cs     = bus.sel.blue;
    assign redgreen_cs = bus.sel.redgreen;
    assign okout       = bus.sel.okout;
    assign main_cs     = bus.sel.rom;

    gng_bus_decode gng_bus_decode_inst (
        .bus       (bus),
        .bank      (bank),
        .ram_q     (ram_dout),
        .char_dout (char_dout),
        .scr_dout  (scr_dout),
        .rom_dout  (rom_dout),
        .cab_dout  (cab_dout),
        .rom_addr  (rom_addr),
        .cpu_din   (cpu_din)
    );

    gng_ctrl_regs #(.coin_w(coin_w)) gng_ctrl_regs_inst (
        .clk       (clk),
        .rst       (rst),
        .soft_rst  (soft_rst),
        .lvbl      (lvbl),
        .irq_ack   (irq_ack),
        .bus       (bus),
        .bank      (bank),
        .flip      (flip),
        .sres_n    (sres_n),
        .cpu_rst   (cpu_rst),
        .irq_n     (irq_n),
        .snd_latch (snd_latch),
        .coin_cnt1 (coin_cnt1),
        .coin_cnt2 (coin_cnt2)
    );

    gng_cabinet_in gng_cabinet_in_inst (
        .bus             (bus),
        .joystick1       (joystick1),
        .joystick2       (joystick2),
        .dip_flip        (dip_flip),
        .dip_game_mode   (dip_game_mode),
        .dip_attract_snd (dip_attract_snd),
        .dip_upright     (dip_upright),
        .cab_dout        (cab_dout)
    );

    gng_work_ram #(.ram_aw(ram_aw)) gng_work_ram_inst (
        .clk      (clk),
        .bus      (bus),
        .blcnten  (blcnten),
        .obj_addr (obj_addr),
        .ram_q    (ram_dout)
    );

endmodule

`default_nettype wire

//--- verif/gng_main_props.sv
`timescale 1ns/1ps
`default_nettype none

module gng_main_props #(
    parameter int coin_w = 4
) (
    input wire              clk,
    input wire              rst,
    input wire              wr,          // Bus write strobe inside the register block
    input wire              lvbl,        // Low during vertical blank
    input wire              irq_n,
    input wire              sres_n,
    input wire [coin_w-1:0] coin_cnt1,
    input wire [coin_w-1:0] coin_cnt2
);

    // IRQ follows a VBlank fall, one bus cycle after the first low sample
    irq_after_vblank_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(irq_n) |-> !$past(lvbl, 1) && !$past(lvbl, 2) && !$past(lvbl, 3)
                         && ($past(lvbl, 4) || $past(lvbl, 5)))
        else $error("irq_n fell without a VBlank fall");

    // Counters step by one, and only on a bus write
    coin1_step: assert property (@(posedge clk) disable iff (rst)
        $changed(coin_cnt1) |-> $past(wr) && (coin_cnt1 == $past(coin_cnt1) + coin_w'(1)))
        else $error("coin_cnt1 moved by other than one bus write step");

    coin2_step: assert property (@(posedge clk) disable iff (rst)
        $changed(coin_cnt2) |-> $past(wr) && (coin_cnt2 == $past(coin_cnt2) + coin_w'(1)))
        else $error("coin_cnt2 moved by other than one bus write step");

    // Both active-low outputs idle high out of reset
    idle_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> sres_n && irq_n)
        else $error("sres_n or irq_n low after reset");

endmodule

bind gng_ctrl_regs gng_main_props #(.coin_w(coin_w)) props_inst (
    .clk       (clk),
    .rst       (rst),
    .wr        (wr),
    .lvbl      (lvbl),
    .irq_n     (irq_n),
    .sres_n    (sres_n),
    .coin_cnt1 (coin_cnt1),
    .coin_cnt2 (coin_cnt2)
);

`default_nettype wire

//--- verif/gng_main_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gng_main_tb;

    localparam int ram_aw   = 13;
    localparam int coin_w   = 4;
    localparam int wait_max = 40;          // Clocks any single wait may take

    logic              clk;
    logic              rst;
    logic              soft_rst;
    logic              cen6;
    logic [15:0]       cpu_addr;
    logic [7:0]        cpu_dout;
    logic              cpu_rnw;
    wire  [7:0]        cpu_din;
    logic              irq_ack;
    logic              lvbl;
    wire               irq_n;
    wire               cpu_rst;
    logic [7:0]        char_dout;
    logic [7:0]        scr_dout;
    logic [7:0]        rom_dout;
    wire  [16:0]       rom_addr;
    logic              blcnten;
    logic [8:0]        obj_addr;
    wire  [7:0]        ram_dout;
    wire               char_cs;
    wire               scr_cs;
    wire               scrpos_cs;
    wire               blue_cs;
    wire               redgreen_cs;
    wire               okout;
    wire               main_cs;
    wire               flip;
    wire               sres_n;
    wire  [7:0]        snd_latch;
    wire  [coin_w-1:0] coin_cnt1;
    wire  [coin_w-1:0] coin_cnt2;
    logic [7:0]        joystick1;
    logic [7:0]        joystick2;
    logic              dip_flip;
    logic              dip_game_mode;
    logic              dip_attract_snd;
    logic              dip_upright;

    // Pending comparisons, drained at the falling edge
    string       chk_name[$];
    logic [31:0] chk_got[$];
    logic [31:0] chk_exp[$];
    time         chk_time[$];
    int          errors;
    int          checks;
    int          test_base;
    int          tests_done;
    logic [7:0]  ram_model [0:8191];

    gng_main_bus #(.ram_aw(ram_aw), .coin_w(coin_w)) gng_main_bus_inst (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;            // 100 ns period
    end

    always @(posedge clk) cen6 <= ~cen6;   // Bus cycle every other clock

    // Compare process
    always @(negedge clk) begin
        string       n;
        logic [31:0] g;
        logic [31:0] e;
        time         t;
        while (chk_name.size() > 0) begin
            n = chk_name.pop_front();
            g = chk_got.pop_front();
            e = chk_exp.pop_front();
            t = chk_time.pop_front();
            checks++;
            assert (g === e) else begin
                $display("FAIL %0d ns %s got %h expected %h", t, n, g, e);
                errors++;
            end
        end
    end

    task automatic expect_val(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        chk_name.push_back(name);
        chk_got.push_back(got);
        chk_exp.push_back(exp);
        chk_time.push_back($time);
    endtask

    // Expected {chr, scr, scrpos, blue, redgreen, okout, rom} for an address
    function automatic logic [6:0] decode_selects(input logic [15:0] a);
        if (a >= 16'h4000)
            return 7'b0000001;
        else if (a < 16'h2000)
            return 7'b0000000;
        else if (a < 16'h2800)
            return 7'b1000000;
        else if (a < 16'h3000)
            return 7'b0100000;
        case (a[15:8])
            8'h38:   return 7'b0000100;
            8'h39:   return 7'b0001000;
            8'h3b:   return 7'b0010000;
            8'h3c:   return 7'b0000010;
            default: return 7'b0000000;    // Cabinet, latch, ctrl, bank, gap
        endcase
    endfunction

    function automatic logic [16:0] bank_rom_addr(input logic [15:0] a, input logic [2:0] b);
        logic [3:0] pg;
        if (a >= 16'h8000)
            pg = {2'b00, a[14:13]};
        else if (a >= 16'h6000)
            pg = 4'd5;
        else if (a >= 16'h4000)
            pg = (b == 3'd4) ? 4'd4 : 4'd6 + {2'b00, b[1:0]};
        else
            pg = 4'd0;
        return {pg, a[12:0]};
    endfunction

    function automatic logic [7:0] cabinet_byte(input logic [3:0] a);
        case (a)
            4'd0:    return {joystick2[7], joystick1[7], 4'hf, joystick2[6], joystick1[6]};
            4'd1:    return {2'b11, joystick1[5:0]};
            4'd2:    return {2'b11, joystick2[5:0]};
            4'd3:    return {dip_flip, dip_game_mode, dip_attract_snd,
                             gng_main_pkg::dipsw_a_coin};
            4'd4:    return gng_main_pkg::dipsw_b_fixed | {5'b0, dip_upright, 2'b0};
            default: return 8'hff;
        endcase
    endfunction

    // One CPU bus cycle; returns just after the cen6 edge
    task automatic bus_access(input logic [15:0] a, input logic [7:0] d, input logic rnw);
        int n;
        n = 0;
        @(posedge clk);
        while (cen6 !== 1'b0 && n < wait_max) begin
            @(posedge clk);
            n++;
        end
        if (cen6 !== 1'b0) begin
            $display("Timed out waiting for a free bus cycle");
            errors++;
        end
        cpu_addr <= a;
        cpu_dout <= d;
        cpu_rnw  <= rnw;
        @(posedge clk);                    // Write lands on this edge
        cpu_rnw  <= 1'b1;
        #1;
    endtask

    function automatic logic watched(input int which);
        return (which == 0) ? irq_n : cpu_rst;
    endfunction

    task automatic wait_for(input int which, input logic level, input string what);
        int n;
        n = 0;
        while (watched(which) !== level && n < wait_max) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (watched(which) !== level) begin
            $display("Timed out waiting for %s", what);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        @(negedge clk);
        #1;
        if (errors == test_base)
            $display("Test %0d %s: ok", tests_done + 1, name);
        else
            $display("Test %0d %s: %0d errors", tests_done + 1, name, errors - test_base);
        test_base = errors;
        tests_done++;
    endtask

    initial begin
        #5_000_000;
        $display("Run limit reached, simulation stuck");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [15:0] a;
        logic [7:0]  d;
        logic [2:0]  bank_v;
        logic [3:0]  c1;
        logic [3:0]  c2;
        logic [6:0]  s;
        logic [15:0] ram_addrs[$];
        logic [8:0]  top_offs[8];
        rst = 1'b1;
        soft_rst = 1'b0;
        cen6 = 1'b0;
        cpu_addr = 16'h0000;
        cpu_dout = 8'h00;
        cpu_rnw = 1'b1;
        irq_ack = 1'b0;
        lvbl = 1'b1;
        char_dout = 8'hc5;
        scr_dout = 8'h5c;
        rom_dout = 8'ha7;
        blcnten = 1'b0;
        obj_addr = 9'd0;
        joystick1 = 8'hff;
        joystick2 = 8'hff;
        dip_flip = 1'b0;
        dip_game_mode = 1'b0;
        dip_attract_snd = 1'b0;
        dip_upright = 1'b0;
        errors = 0;
        checks = 0;
        test_base = 0;
        tests_done = 0;
        void'($urandom(75));
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        wait_for(1, 1'b0, "cpu_rst release after reset");

        // Test 1: chip selects
        for (int i = 0; i < 200; i++) begin
            a = 16'($urandom);
            if ($urandom % 2)
                a = 16'h3800 | (a & 16'h07ff);   // Bias into the I/O page
            @(posedge clk);
            cpu_addr <= a;
            #1;
            s = decode_selects(a);
            expect_val("selects", {25'd0, char_cs, scr_cs, scrpos_cs, blue_cs,
                                   redgreen_cs, okout, main_cs}, {25'd0, s});
        end
        finish_test("chip selects");

        // Test 2: banked ROM address
        for (int k = 0; k < 4; k++) begin
            bank_v = 3'($urandom);
            if (k == 0)
                bank_v = 3'd4;
            bus_access(16'h3e00, {5'd0, bank_v}, 1'b0);
            for (int i = 0; i < 48; i++) begin
                a = 16'h4000 + 16'(i * 1024) + 16'($urandom & 32'h3ff);
                @(posedge clk);
                cpu_addr <= a;
                #1;
                expect_val("rom_addr", {15'd0, rom_addr}, {15'd0, bank_rom_addr(a, bank_v)});
            end
        end
        finish_test("ROM banking");

        // Test 3: control registers
        c1 = 4'd0;
        c2 = 4'd0;
        for (int i = 0; i < 20; i++) begin
            d = 8'($urandom);
            bus_access(16'h3d00, d, 1'b0);
            expect_val("flip", {31'd0, flip}, {31'd0, d[0]});
            d = 8'($urandom);
            bus_access(16'h3d01, d, 1'b0);
            expect_val("sres_n", {31'd0, sres_n}, {31'd0, d[0]});
            d = 8'($urandom);
            bus_access(16'h3a00, d, 1'b0);
            expect_val("snd_latch", {24'd0, snd_latch}, {24'd0, d});
            d = 8'($urandom);
            bus_access(16'h3d02, d, 1'b0);
            c1 = c1 + {3'b000, d[0]};          // Wraps at 16
            expect_val("coin_cnt1", {28'd0, coin_cnt1}, {28'd0, c1});
            d = 8'($urandom);
            bus_access(16'h3d03, d, 1'b0);
            c2 = c2 + {3'b000, d[0]};
            expect_val("coin_cnt2", {28'd0, coin_cnt2}, {28'd0, c2});
        end
        finish_test("control registers");

        // Test 4: work RAM and object takeover
        for (int i = 0; i < 32; i++) begin
            if (i < 8) begin
                top_offs[i] = 9'(i * 61 + ($urandom % 40));
                a = 16'h1e00 | {7'd0, top_offs[i]};
            end else begin
                a = 16'($urandom) & 16'h1dff;
            end
            d = 8'($urandom);
            bus_access(a, d, 1'b0);
            ram_model[a[12:0]] = d;
            ram_addrs.push_back(a);
        end
        foreach (ram_addrs[i]) begin
            bus_access(ram_addrs[i], 8'h00, 1'b1);
            expect_val("cpu_din", {24'd0, cpu_din}, {24'd0, ram_model[ram_addrs[i][12:0]]});
        end
        for (int i = 0; i < 8; i++) begin
            a = ram_addrs[i + 8];                  // CPU aims below the top page
            @(posedge clk);
            blcnten  <= 1'b1;
            obj_addr <= top_offs[i];
            bus_access(a, ~ram_model[a[12:0]], 1'b0);   // Must be blocked
            expect_val("ram_dout", {24'd0, ram_dout},
                       {24'd0, ram_model[13'h1e00 | {4'd0, top_offs[i]}]});
        end
        @(posedge clk);
        blcnten <= 1'b0;
        for (int i = 0; i < 8; i++) begin
            a = 16'h1e00 | {7'd0, top_offs[i]};
            bus_access(a, 8'h00, 1'b1);
            expect_val("cpu_din", {24'd0, cpu_din}, {24'd0, ram_model[a[12:0]]});
            a = ram_addrs[i + 8];
            bus_access(a, 8'h00, 1'b1);
            expect_val("cpu_din", {24'd0, cpu_din}, {24'd0, ram_model[a[12:0]]});
        end
        finish_test("work RAM");

        // Test 5: cabinet inputs
        for (int r = 0; r < 10; r++) begin
            @(posedge clk);
            joystick1       <= 8'($urandom);
            joystick2       <= 8'($urandom);
            dip_flip        <= 1'($urandom);
            dip_game_mode   <= 1'($urandom);
            dip_attract_snd <= 1'($urandom);
            dip_upright     <= 1'($urandom);
            for (int k = 0; k < 8; k++) begin
                @(posedge clk);
                cpu_addr <= 16'h3000 + 16'(k);
                #1;
                expect_val("cpu_din", {24'd0, cpu_din}, {24'd0, cabinet_byte(4'(k))});
            end
        end
        finish_test("cabinet inputs");

        // Test 6: VBlank IRQ and held CPU reset
        expect_val("irq_n", {31'd0, irq_n}, 32'd1);
        @(posedge clk);
        lvbl <= 1'b0;
        wait_for(0, 1'b0, "irq_n to assert after VBlank");
        @(posedge clk);
        irq_ack <= 1'b1;
        wait_for(0, 1'b1, "irq_n to clear on acknowledge");
        @(posedge clk);
        irq_ack <= 1'b0;
        soft_rst <= 1'b1;
        wait_for(1, 1'b1, "cpu_rst to follow soft_rst");
        @(posedge clk);
        soft_rst <= 1'b0;
        wait_for(1, 1'b0, "cpu_rst to clear");
        @(posedge clk);
        lvbl <= 1'b1;
        finish_test("IRQ and reset");

        $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hw/gng_main_pkg.sv
hw/gng_cpu_bus_if.sv
hw/gng_bus_decode.sv
hw/gng_ctrl_regs.sv
hw/gng_cabinet_in.sv
hw/gng_work_ram.sv
hw/gng_main_bus.sv
verif/gng_main_props.sv
verif/gng_main_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator and run; exit status follows the testbench result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module gng_main_tb -f list.f -o gng_main_sim \
    || exit 1
out="$(./obj_dir/gng_main_sim)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'SIMULATION PASSED' && exit 0 || exit 1
